// ==== source/sdhc_pkg.sv ====
/* Register map, BLOCK register layout and PRESENT bit positions.
   Block size is in bytes and wider sizes are truncated to MaxBlockBits. */
`default_nettype none

package sdhc_pkg;

  // Defaults for the buffer depth and the block size width
  localparam int unsigned DEF_NUM_WORDS      = 16;
  localparam int unsigned DEF_MAX_BLOCK_BITS = 10;

  // Host register addresses
  typedef enum logic [3:0] {
    BLOCK     = 4'd0,
    XFER_MODE = 4'd1,
    DATA_PORT = 4'd2,
    PRESENT   = 4'd3
  } reg_addr_e;

  // BLOCK register, count in the upper half
  typedef struct packed {
    logic [15:0] block_count;
    logic [3:0]  reserved;
    logic [11:0] block_size;
  } blk_reg_t;

  // Written as a raw word, decoded as fields
  typedef union packed {
    logic [31:0] raw;
    blk_reg_t    fields;
  } blk_reg_u;

  // PRESENT word bits
  localparam int unsigned PS_WR_EN_BIT = 0;
  localparam int unsigned PS_RD_EN_BIT = 1;

  // Multi/single block select in XFER_MODE
  localparam int unsigned XM_MULTI_BIT = 5;

endpackage

`default_nettype wire

// ==== source/buf_fifo_if.sv ====
/* Link between the buffer control and the word queue.
   Length counts words and ranges from zero to NumWords. */
`timescale 1ns/1ps
`default_nettype none

interface buf_fifo_if #(
  parameter int unsigned NumWords = 16
);
  localparam int unsigned LenW = $clog2(NumWords + 1);

  // Control side
  logic            en;
  logic            push;
  logic [31:0]     push_data;
  logic            pop;

  // Storage side
  logic [31:0]     pop_data;
  logic            full;
  logic            empty;
  logic [LenW-1:0] length;

  modport ctrl (
    output en, push, push_data, pop,
    input  pop_data, full, empty, length
  );

  modport store (
    input  en, push, push_data, pop,
    output pop_data, full, empty, length
  );

endinterface

`default_nettype wire

// ==== source/word_fifo.sv ====
/* First-word-fall-through queue on a register array, no SRAM macro.
   A push into a full queue is dropped and a pop from an empty one is ignored.
   Low en empties the queue at the next edge. */
`timescale 1ns/1ps
`default_nettype none

module word_fifo import sdhc_pkg::*; #(
  parameter int unsigned NumWords = DEF_NUM_WORDS
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  buf_fifo_if.store  fifo_if
);
  localparam int unsigned PtrW = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam int unsigned LenW = $clog2(NumWords + 1);

  logic [31:0]     mem [NumWords];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [LenW-1:0] len_q;
  logic            do_push;
  logic            do_pop;

  // Wrap at NumWords so non power of two depths work
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    if (ptr == PtrW'(NumWords - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + PtrW'(1);
    end
    return nxt;
  endfunction

  assign fifo_if.full     = (len_q == LenW'(NumWords));
  assign fifo_if.empty    = (len_q == '0);
  assign fifo_if.length   = len_q;
  assign fifo_if.pop_data = mem[rd_ptr_q];

  assign do_push = fifo_if.push && !fifo_if.full;
  assign do_pop  = fifo_if.pop && !fifo_if.empty;

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !fifo_if.en) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      len_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   len_q <= len_q + LenW'(1);
        2'b01:   len_q <= len_q - LenW'(1);
        default: len_q <= len_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= fifo_if.push_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/data_buffer.sv ====
/* Buffer control for one operation at a time; read_op_i takes priority.
   Enables compare free or stored bytes against block_size, counted per block.
   Multi-block mode counts block_count down to one. No infinite transfers. */
`timescale 1ns/1ps
`default_nettype none

module data_buffer import sdhc_pkg::*; #(
  parameter int unsigned NumWords     = DEF_NUM_WORDS,
  parameter int unsigned MaxBlockBits = DEF_MAX_BLOCK_BITS
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        read_op_i,
  input  wire logic        write_op_i,

  // Card stream out during a write operation
  input  wire logic        card_rready_i,
  output logic             card_rvalid_o,
  output logic [31:0]      card_rdata_o,

  // Card stream in during a read operation
  input  wire logic        card_wvalid_i,
  input  wire logic [31:0] card_wdata_i,
  output logic             card_wready_o,

  output logic             empty_o,

  input  wire blk_reg_u    blk_i,
  input  wire logic        multi_blk_i,

  // Host data port
  input  wire logic        dp_wr_i,
  input  wire logic [31:0] dp_wdata_i,
  input  wire logic        dp_rd_i,
  output logic [31:0]      dp_rdata_o,

  // Present-state and block count next values
  output logic             wr_en_o,
  output logic             rd_en_o,
  output logic             blk_cnt_load_o,
  output logic [15:0]      blk_cnt_o,

  buf_fifo_if.ctrl         fifo_if
);
  localparam int unsigned LenW  = $clog2(NumWords + 1);
  localparam int unsigned ByteW = LenW + 2;
  localparam int unsigned CmpW  = (ByteW > MaxBlockBits) ? ByteW : MaxBlockBits;
  localparam int unsigned SizeW = MaxBlockBits + 1;
  localparam int unsigned WordW = MaxBlockBits - 1;

  logic [MaxBlockBits-1:0] block_size;
  logic [SizeW-1:0]        size_rnd;
  logic [WordW-1:0]        last_word;
  logic [WordW-1:0]        word_cnt_q;
  logic [WordW-1:0]        word_cnt_d;
  logic [ByteW-1:0]        stored_bytes;
  logic [ByteW-1:0]        free_bytes;
  logic                    has_space;
  logic                    has_block;
  logic                    dp_access;
  logic                    blk_end;

  assign block_size = MaxBlockBits'(blk_i.fields.block_size);

  // Words per block rounded up
  assign size_rnd  = {1'b0, block_size} + SizeW'(3);
  assign last_word = size_rnd[MaxBlockBits:2] - WordW'(1);

  assign stored_bytes = {fifo_if.length, 2'b00};
  assign free_bytes   = ByteW'(NumWords * 4) - stored_bytes;
  assign has_space    = CmpW'(free_bytes) >= CmpW'(block_size);
  assign has_block    = CmpW'(stored_bytes) >= CmpW'(block_size);

  // Flush whenever no operation runs
  assign fifo_if.en = read_op_i || write_op_i;
  assign empty_o    = fifo_if.empty;

  assign card_rdata_o = fifo_if.pop_data;
  assign dp_rdata_o   = fifo_if.pop_data;
  assign blk_cnt_o    = blk_i.fields.block_count - 16'd1;

  assign dp_access = (read_op_i && dp_rd_i) || (write_op_i && dp_wr_i);
  assign blk_end   = dp_access && (word_cnt_q == last_word);

  always_comb begin
    fifo_if.push      = 1'b0;
    fifo_if.push_data = dp_wdata_i;
    fifo_if.pop       = 1'b0;
    card_rvalid_o     = 1'b0;
    card_wready_o     = 1'b0;
    wr_en_o           = 1'b0;
    rd_en_o           = 1'b0;
    blk_cnt_load_o    = 1'b0;

    if (read_op_i) begin
      // Card fills, host drains
      card_wready_o     = has_space;
      fifo_if.push      = card_wvalid_i && has_space;
      fifo_if.push_data = card_wdata_i;
      fifo_if.pop       = dp_rd_i;
      rd_en_o           = has_block;
    end else if (write_op_i) begin
      // Host fills, card drains a whole block
      card_rvalid_o = has_block;
      fifo_if.pop   = card_rready_i && has_block;
      fifo_if.push  = dp_wr_i;
      wr_en_o       = has_space;
    end

    // Count down with a one-cycle gap in the enables while more blocks follow
    if (blk_end && multi_blk_i && (blk_i.fields.block_count != 16'd1)) begin
      blk_cnt_load_o = 1'b1;
      wr_en_o        = 1'b0;
      rd_en_o        = 1'b0;
    end
  end

  always_comb begin
    word_cnt_d = word_cnt_q;
    if (blk_end) begin
      word_cnt_d = '0;
    end else if (dp_access) begin
      word_cnt_d = word_cnt_q + WordW'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !fifo_if.en) begin
      word_cnt_q <= '0;
    end else begin
      word_cnt_q <= word_cnt_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/host_reg_port.sv ====
/* Host register port with single-cycle strobes and no back-pressure.
   Read data returns one cycle after reg_rd_i; unmapped addresses read zero. */
`timescale 1ns/1ps
`default_nettype none

module host_reg_port import sdhc_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,

  input  wire logic        reg_wr_i,
  input  wire logic        reg_rd_i,
  input  wire logic [3:0]  reg_addr_i,
  input  wire logic [31:0] reg_wdata_i,
  output logic [31:0]      reg_rdata_o,
  output logic             reg_rvalid_o,

  output blk_reg_u         blk_o,
  output logic             multi_blk_o,

  output logic             dp_wr_o,
  output logic [31:0]      dp_wdata_o,
  output logic             dp_rd_o,
  input  wire logic [31:0] dp_rdata_i,

  input  wire logic        wr_en_i,
  input  wire logic        rd_en_i,
  input  wire logic        blk_cnt_load_i,
  input  wire logic [15:0] blk_cnt_i
);
  reg_addr_e   addr;
  blk_reg_u    blk_q;
  logic [31:0] xfer_q;
  logic        wr_en_q;
  logic        rd_en_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        rvalid_q;

  assign addr = reg_addr_e'(reg_addr_i);

  // Data port accesses become strobes toward the buffer
  assign dp_wr_o    = reg_wr_i && (addr == DATA_PORT);
  assign dp_rd_o    = reg_rd_i && (addr == DATA_PORT);
  assign dp_wdata_o = reg_wdata_i;

  assign blk_o        = blk_q;
  assign multi_blk_o  = xfer_q[XM_MULTI_BIT];
  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      blk_q.raw <= '0;
      xfer_q    <= '0;
      wr_en_q   <= 1'b0;
      rd_en_q   <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      // Host write wins over a count reload in the same cycle
      if (reg_wr_i && (addr == BLOCK)) begin
        blk_q.raw <= reg_wdata_i;
      end else if (blk_cnt_load_i) begin
        blk_q.fields.block_count <= blk_cnt_i;
      end
      if (reg_wr_i && (addr == XFER_MODE)) begin
        xfer_q <= reg_wdata_i;
      end
      wr_en_q  <= wr_en_i;
      rd_en_q  <= rd_en_i;
      rvalid_q <= reg_rd_i;
    end
  end

  // Readback mux
  always_comb begin
    rdata_d = '0;
    case (addr)
      BLOCK:     rdata_d = blk_q.raw;
      XFER_MODE: rdata_d = xfer_q;
      DATA_PORT: rdata_d = dp_rdata_i;
      PRESENT: begin
        rdata_d[PS_WR_EN_BIT] = wr_en_q;
        rdata_d[PS_RD_EN_BIT] = rd_en_q;
      end
      default:   rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reg_rd_i) begin
      rdata_q <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/sdhc_data_top.sv ====
/* Data buffer path of the SD host, without SD bus, CRC, DMA or interrupts.
   read_op_i and write_op_i must not be high together. */
`timescale 1ns/1ps
`default_nettype none

module sdhc_data_top import sdhc_pkg::*; #(
  parameter int unsigned NumWords     = DEF_NUM_WORDS,
  parameter int unsigned MaxBlockBits = DEF_MAX_BLOCK_BITS
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  input  wire logic        read_op_i,
  input  wire logic        write_op_i,

  // Host register port
  input  wire logic        reg_wr_i,
  input  wire logic        reg_rd_i,
  input  wire logic [3:0]  reg_addr_i,
  input  wire logic [31:0] reg_wdata_i,
  output logic [31:0]      reg_rdata_o,
  output logic             reg_rvalid_o,

  // Card streams
  input  wire logic        card_rready_i,
  output logic             card_rvalid_o,
  output logic [31:0]      card_rdata_o,
  input  wire logic        card_wvalid_i,
  input  wire logic [31:0] card_wdata_i,
  output logic             card_wready_o,

  output logic             empty_o
);
  blk_reg_u    blk;
  logic        multi_blk;
  logic        dp_wr;
  logic [31:0] dp_wdata;
  logic        dp_rd;
  logic [31:0] dp_rdata;
  logic        wr_en;
  logic        rd_en;
  logic        blk_cnt_load;
  logic [15:0] blk_cnt;

  buf_fifo_if #(.NumWords(NumWords)) u_fifo_if ();

  host_reg_port u_host_reg_port (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reg_wr_i       (reg_wr_i),
    .reg_rd_i       (reg_rd_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .reg_rdata_o    (reg_rdata_o),
    .reg_rvalid_o   (reg_rvalid_o),
    .blk_o          (blk),
    .multi_blk_o    (multi_blk),
    .dp_wr_o        (dp_wr),
    .dp_wdata_o     (dp_wdata),
    .dp_rd_o        (dp_rd),
    .dp_rdata_i     (dp_rdata),
    .wr_en_i        (wr_en),
    .rd_en_i        (rd_en),
    .blk_cnt_load_i (blk_cnt_load),
    .blk_cnt_i      (blk_cnt)
  );

  data_buffer #(
    .NumWords     (NumWords),
    .MaxBlockBits (MaxBlockBits)
  ) u_data_buffer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .read_op_i      (read_op_i),
    .write_op_i     (write_op_i),
    .card_rready_i  (card_rready_i),
    .card_rvalid_o  (card_rvalid_o),
    .card_rdata_o   (card_rdata_o),
    .card_wvalid_i  (card_wvalid_i),
    .card_wdata_i   (card_wdata_i),
    .card_wready_o  (card_wready_o),
    .empty_o        (empty_o),
    .blk_i          (blk),
    .multi_blk_i    (multi_blk),
    .dp_wr_i        (dp_wr),
    .dp_wdata_i     (dp_wdata),
    .dp_rd_i        (dp_rd),
    .dp_rdata_o     (dp_rdata),
    .wr_en_o        (wr_en),
    .rd_en_o        (rd_en),
    .blk_cnt_load_o (blk_cnt_load),
    .blk_cnt_o      (blk_cnt),
    .fifo_if        (u_fifo_if.ctrl)
  );

  word_fifo #(
    .NumWords (NumWords)
  ) u_word_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .fifo_if (u_fifo_if.store)
  );

endmodule

`default_nettype wire

// ==== verif/sdhc_data_checker.sv ====
/* Protocol assertions on the data path, bound into the top level.
   Assumes the default buffer interface instance name u_fifo_if. */
`timescale 1ns/1ps
`default_nettype none

module sdhc_data_checker (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic read_op_i,
  input wire logic write_op_i,
  input wire logic push_i,
  input wire logic pop_i,
  input wire logic full_i,
  input wire logic empty_i,
  input wire logic reg_rd_i,
  input wire logic reg_rvalid_i
);

  // Only one operation may run at a time
  a_one_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(read_op_i && write_op_i))
    else $error("read and write operations active together");

  // Host writes into a full buffer are dropped
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(push_i && full_i))
    else $error("push into a full buffer");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pop_i && empty_i))
    else $error("pop from an empty buffer");

  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_rd_i |=> reg_rvalid_i)
    else $error("reg_rvalid_o missing one cycle after a read strobe");

endmodule

bind sdhc_data_top sdhc_data_checker u_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .read_op_i    (read_op_i),
  .write_op_i   (write_op_i),
  .push_i       (u_fifo_if.push),
  .pop_i        (u_fifo_if.pop),
  .full_i       (u_fifo_if.full),
  .empty_i      (u_fifo_if.empty),
  .reg_rd_i     (reg_rd_i),
  .reg_rvalid_i (reg_rvalid_o)
);

`default_nettype wire

// ==== verif/sdhc_data_monitor.sv ====
/* Watches the card stream and the register readback at the rising edge.
   Expected words are queued by the testbench before they appear. */
`timescale 1ns/1ps
`default_nettype none

module sdhc_data_monitor (
  input wire logic        clk_i,
  input wire logic        rst_n_i,
  input wire logic        write_op_i,
  input wire logic        card_rvalid_i,
  input wire logic        card_rready_i,
  input wire logic [31:0] card_rdata_i,
  input wire logic        reg_rvalid_i,
  input wire logic [31:0] reg_rdata_i
);
  logic [31:0] card_exp_q[$];
  logic [31:0] rd_exp_q[$];
  logic        stalled_q;
  logic [31:0] held_q;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  initial begin
    stalled_q    = 1'b0;
    held_q       = '0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
  end

  task automatic check_value(input string sig, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, sig, act, exp);
      test_errors++;
    end
  endtask

  task automatic report(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    test_errors++;
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      // Stalled word must hold until taken, unless the operation ends
      if (stalled_q && write_op_i) begin
        if (!card_rvalid_i) begin
          report("card_rvalid_o dropped while the card was stalled");
        end else begin
          check_value("card_rdata_o", card_rdata_i, held_q);
        end
      end
      if (card_rvalid_i && card_rready_i) begin
        if (card_exp_q.size() == 0) begin
          report("card stream delivered a word that was never written");
        end else begin
          check_value("card_rdata_o", card_rdata_i, card_exp_q.pop_front());
        end
      end
      if (reg_rvalid_i) begin
        if (rd_exp_q.size() == 0) begin
          report("reg_rvalid_o without a pending read");
        end else begin
          check_value("reg_rdata_o", reg_rdata_i, rd_exp_q.pop_front());
        end
      end
      stalled_q <= card_rvalid_i && !card_rready_i;
      held_q    <= card_rdata_i;
    end
  end

  task automatic end_test(input string name);
    if (card_exp_q.size() != 0 || rd_exp_q.size() != 0) begin
      report("expected words were never seen");
      card_exp_q.delete();
      rd_exp_q.delete();
    end
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %-12s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic summary();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
  endtask

endmodule

`default_nettype wire

// ==== verif/tb_sdhc_data.sv ====
/* Testbench for the SD host data buffer path with the default 16-word buffer.
   Inputs change on the falling edge and outputs are read at stable points. */
`timescale 1ns/1ps
`default_nettype none

module tb_sdhc_data import sdhc_pkg::*;;
  localparam int NUM_WORDS = 16;
  localparam int MAX_WAIT  = 200;

  logic clk, rst_n, read_op, write_op;
  logic reg_wr, reg_rd, reg_rvalid;
  logic [3:0]  reg_addr;
  logic [31:0] reg_wdata, reg_rdata;
  logic card_rready, card_rvalid, card_wvalid, card_wready, empty;
  logic [31:0] card_rdata, card_wdata;
  logic [31:0] model_q[$];
  integer      seed;
  int          cur_bsize;

  sdhc_data_top #(.NumWords(NUM_WORDS), .MaxBlockBits(10)) u_dut (
    .clk_i(clk), .rst_n_i(rst_n), .read_op_i(read_op), .write_op_i(write_op),
    .reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata), .reg_rvalid_o(reg_rvalid),
    .card_rready_i(card_rready), .card_rvalid_o(card_rvalid),
    .card_rdata_o(card_rdata), .card_wvalid_i(card_wvalid),
    .card_wdata_i(card_wdata), .card_wready_o(card_wready), .empty_o(empty)
  );

  sdhc_data_monitor u_mon (
    .clk_i(clk), .rst_n_i(rst_n), .write_op_i(write_op),
    .card_rvalid_i(card_rvalid), .card_rready_i(card_rready),
    .card_rdata_i(card_rdata), .reg_rvalid_i(reg_rvalid), .reg_rdata_i(reg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected PRESENT word from the fill level in bytes
  function automatic logic [31:0] ref_present(input int words, input int bsize,
                                              input bit wr_op, input bit rd_op);
    logic [31:0] ps;
    int          stored_b;
    int          free_b;
    ps       = '0;
    stored_b = words * 4;
    free_b   = NUM_WORDS * 4 - stored_b;
    if (rd_op) begin
      ps[PS_RD_EN_BIT] = (stored_b >= bsize);
    end else if (wr_op) begin
      ps[PS_WR_EN_BIT] = (free_b >= bsize);
    end
    return ps;
  endfunction

  // The last block leaves the count at one
  function automatic logic [15:0] ref_blk_count(input int start, input int blocks_done);
    int left;
    left = start - blocks_done;
    if (left < 1) begin
      left = 1;
    end
    return 16'(left);
  endfunction

  task automatic abort(input string msg);
    $display("Timeout: %s", msg);
    $display("Verification failed");
    $finish;
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, input logic [31:0] exp);
    int n;
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    u_mon.rd_exp_q.push_back(exp);
    @(negedge clk);
    reg_rd = 1'b0;
    n = 0;
    while (u_mon.rd_exp_q.size() != 0 && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (u_mon.rd_exp_q.size() != 0) begin
      abort("register readback never arrived");
    end
  endtask

  task automatic set_block(input int count, input int bsize);
    cur_bsize = bsize;
    reg_write(BLOCK, {16'(count), 4'h0, 12'(bsize)});
  endtask

  // PRESENT follows one cycle after the cause, then the read adds one
  task automatic check_present();
    repeat (2) @(negedge clk);
    reg_read(PRESENT, ref_present(model_q.size(), cur_bsize, write_op, read_op));
  endtask

  task automatic host_push(input logic [31:0] data);
    reg_write(DATA_PORT, data);
    model_q.push_back(data);
  endtask

  task automatic card_push(input logic [31:0] data);
    int n;
    n = 0;
    while (!card_wready && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!card_wready) begin
      abort("card_wready_o never rose");
    end
    card_wvalid = 1'b1;
    card_wdata  = data;
    @(negedge clk);
    card_wvalid = 1'b0;
    model_q.push_back(data);
  endtask

  task automatic drain(input bit stall);
    int n;
    while (model_q.size() != 0) begin
      u_mon.card_exp_q.push_back(model_q.pop_front());
    end
    n = 0;
    while (u_mon.card_exp_q.size() != 0 && n < MAX_WAIT) begin
      card_rready = stall ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      n++;
    end
    card_rready = 1'b0;
    if (u_mon.card_exp_q.size() != 0) begin
      abort("card stream did not deliver all words");
    end
  endtask

  task automatic check_empty(input logic exp);
    u_mon.check_value("empty_o", {31'b0, empty}, {31'b0, exp});
  endtask

  initial begin
    int n;
    seed = 32'h8717cf79;
    {read_op, write_op, reg_wr, reg_rd, card_rready, card_wvalid} = '0;
    reg_addr   = '0;
    reg_wdata  = '0;
    card_wdata = '0;
    cur_bsize  = 0;
    rst_n      = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    check_empty(1'b1);
    u_mon.check_value("card_rvalid_o", {31'b0, card_rvalid}, 32'd0);
    u_mon.check_value("card_wready_o", {31'b0, card_wready}, 32'd0);
    reg_read(PRESENT, ref_present(0, 0, 1'b0, 1'b0));
    u_mon.end_test("reset");

    set_block(1, 16);
    reg_write(XFER_MODE, 32'd0);
    write_op = 1'b1;
    check_present();
    for (int i = 0; i < 4; i++) begin
      host_push($random(seed));
      check_present();
    end
    // Smaller blocks let the card drain word by word
    set_block(1, 4);
    drain(1'b0);
    @(negedge clk);
    check_empty(1'b1);
    write_op = 1'b0;
    u_mon.end_test("write");

    set_block(1, 16);
    read_op = 1'b1;
    check_present();
    for (int i = 0; i < 4; i++) begin
      card_push($random(seed));
    end
    check_present();
    for (int i = 0; i < 4; i++) begin
      reg_read(DATA_PORT, model_q.pop_front());
    end
    check_empty(1'b1);
    read_op = 1'b0;
    u_mon.end_test("read");

    set_block(1, 4);
    write_op = 1'b1;
    for (int i = 0; i < 8; i++) begin
      host_push($random(seed));
    end
    drain(1'b1);
    @(negedge clk);
    check_empty(1'b1);
    write_op = 1'b0;
    u_mon.end_test("backpressure");

    set_block(3, 8);
    reg_write(XFER_MODE, 32'(1) << XM_MULTI_BIT);
    write_op = 1'b1;
    for (int b = 1; b <= 3; b++) begin
      host_push($random(seed));
      host_push($random(seed));
      repeat (2) @(negedge clk);
      reg_read(BLOCK, {ref_blk_count(3, b), 4'h0, 12'd8});
      check_present();
    end
    u_mon.end_test("multi_block");

    // Six words still stored from the previous test
    check_empty(1'b0);
    write_op = 1'b0;
    n = 0;
    while (!empty && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!empty) begin
      abort("empty_o never rose after the flush");
    end
    check_empty(1'b1);
    model_q.delete();
    reg_write(XFER_MODE, 32'd0);
    set_block(1, 4);
    write_op = 1'b1;
    host_push($random(seed));
    host_push($random(seed));
    drain(1'b0);
    @(negedge clk);
    check_empty(1'b1);
    write_op = 1'b0;
    u_mon.end_test("flush");

    u_mon.summary();
    if (u_mon.total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/sdhc_pkg.sv
source/buf_fifo_if.sv
source/word_fifo.sv
source/data_buffer.sv
source/host_reg_port.sv
source/sdhc_data_top.sv
verif/sdhc_data_checker.sv
verif/sdhc_data_monitor.sv
verif/tb_sdhc_data.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sdhc_data
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
